/* fpga_consts.svh */
// Fabric constants
`ifndef FPGA_CONSTS_SVH
`define FPGA_CONSTS_SVH

// Fabric geometry
`define FAB_N_TILES     8
`define FAB_LUT_K       3
// One tile segment is oe, reg_en and an 8-entry LUT
`define FAB_CFG_BITS    10
`define FAB_CHAIN_BITS  80
`define FAB_WORD_BITS   32

// Pad frame and analyzer lines
`define MPRJ_IO_PADS    38
`define FAB_LA_BITS     32

// Pad assignment
`define PAD_MODE_PIN    0
`define PAD_IN_LO       1
`define PAD_IN_HI       24
`define PAD_OUT_LO      25
`define PAD_OUT_HI      32
`define PAD_CCFF_TAIL   37
`define LA_OUT_LO       24

// Loader register map, low address byte only
`define CFG_DATA_ADDR   8'h00
`define CFG_STAT_ADDR   8'h04

`endif

/* fabric_pkg.sv */
// Fabric types
`include "fpga_consts.svh"

package fabric_pkg;

    // Per-tile configuration segment
    // Field order fixes the chain position of each bit:
    // oe sits at the head end (bit 9), lut[0] at the tail end (bit 0)
    typedef struct packed {
        // Drive the tile output pad
        logic       oe;
        // Present the registered LUT result
        logic       reg_en;
        // Truth table, indexed by the tile inputs
        logic [7:0] lut;
    } tile_cfg_t;

    // Input group of one tile
    // Bit 0 is LUT index bit 0
    typedef logic [`FAB_LUT_K-1:0] tile_in_t;

endpackage

/* pad_pkg.sv */
// Pad-side types
`include "fpga_consts.svh"

package pad_pkg;

    // Source of the tile inputs, taken from the mode pad
    // GPIO mode reads the input pads,
    // LA mode reads the masked analyzer lines
    typedef enum logic {
        PAD_MODE_GPIO = 1'b0,
        PAD_MODE_LA   = 1'b1
    } pad_mode_e;

endpackage

/* config_loader.sv */
// Configuration chain loader
`timescale 1ns/100ps
`include "fpga_consts.svh"

module config_loader (
    input  logic                      wb_clk_i,
    input  logic                      reset_i,
    input  logic                      wbs_cyc_i,
    input  logic                      wbs_stb_i,
    input  logic                      wbs_we_i,
    input  logic [3:0]                wbs_sel_i,
    input  logic [31:0]               wbs_adr_i,
    input  logic [`FAB_WORD_BITS-1:0] wbs_dat_i,
    output logic                      wbs_ack_o,
    output logic [`FAB_WORD_BITS-1:0] wbs_dat_o,
    output logic                      cfg_shift_o,
    output logic                      cfg_bit_o,
    output logic                      busy_o
);

    localparam int CNT_W = $clog2(`FAB_WORD_BITS);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`FAB_WORD_BITS - 1);

    logic                      ack_q;
    logic                      busy_q;
    logic [CNT_W-1:0]          bit_cnt_q;
    logic [`FAB_WORD_BITS-1:0] shift_buf_q;
    logic [`FAB_WORD_BITS-1:0] rdata_q;
    logic [`FAB_WORD_BITS-1:0] wdata_masked;
    logic                      req;
    logic                      data_sel;
    logic                      stat_sel;
    logic                      data_wr;
    logic                      accept;
    logic                      take_word;

    // New request, the ack cycle itself excluded so each transfer acks once
    assign req      = wbs_cyc_i && wbs_stb_i && !ack_q;
    assign data_sel = (wbs_adr_i[7:0] == `CFG_DATA_ADDR);
    assign stat_sel = (wbs_adr_i[7:0] == `CFG_STAT_ADDR);
    assign data_wr  = req && wbs_we_i && data_sel;

    // A data write stalls while a word is still shifting out
    assign accept    = req && !(data_wr && busy_q);
    assign take_word = data_wr && !busy_q;

    // Byte lanes not selected load as zero
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            wdata_masked[8*b +: 8] = wbs_sel_i[b] ? wbs_dat_i[8*b +: 8] : 8'h00;
        end
    end

    // Handshake and shift sequencing
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            ack_q     <= 1'b0;
            busy_q    <= 1'b0;
            bit_cnt_q <= '0;
        end else begin
            ack_q <= accept;
            if (take_word) begin
                busy_q    <= 1'b1;
                bit_cnt_q <= '0;
            end else if (busy_q) begin
                bit_cnt_q <= bit_cnt_q + 1'b1;
                // Final shift happens on this edge
                if (bit_cnt_q == LAST_BIT) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    // Word buffer, LSB leaves first
    always_ff @(posedge wb_clk_i) begin
        if (take_word) begin
            shift_buf_q <= wdata_masked;
        end else if (busy_q) begin
            shift_buf_q <= shift_buf_q >> 1;
        end
    end

    // Read data, busy in bit 0 of status, all else reads 0
    always_ff @(posedge wb_clk_i) begin
        if (accept && !wbs_we_i) begin
            rdata_q <= stat_sel ? {{(`FAB_WORD_BITS-1){1'b0}}, busy_q} : '0;
        end
    end

    assign wbs_ack_o   = ack_q;
    assign wbs_dat_o   = rdata_q;
    assign cfg_shift_o = busy_q;
    assign cfg_bit_o   = shift_buf_q[0];
    assign busy_o      = busy_q;

endmodule

/* logic_tile.sv */
// Logic tile
`timescale 1ns/100ps
`include "fpga_consts.svh"

module logic_tile
    import fabric_pkg::*;
(
    input  logic     wb_clk_i,
    input  logic     reset_i,
    input  logic     cfg_shift_i,
    input  logic     ccff_head_i,
    input  tile_in_t tile_in_i,
    output logic     ccff_tail_o,
    output logic     tile_out_o,
    output logic     tile_oe_o
);

    // Chain segment as a flat vector, bit 0 is the tail
    logic [`FAB_CFG_BITS-1:0] cfg_q;
    tile_cfg_t                cfg;
    logic                     lut_bit;
    logic                     out_q;

    // Field view of the segment
    assign cfg = cfg_q;

    // Configuration shift segment
    // New bit enters at the top, bit 0 moves on to the next tile
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            cfg_q <= '0;
        end else if (cfg_shift_i) begin
            cfg_q <= {ccff_head_i, cfg_q[`FAB_CFG_BITS-1:1]};
        end
    end

    assign ccff_tail_o = cfg_q[0];

    // LUT lookup, tile inputs form the table index
    assign lut_bit = cfg.lut[tile_in_i];

    // Optional output flop, tracks the LUT every cycle when enabled
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            out_q <= 1'b0;
        end else if (cfg.reg_en) begin
            out_q <= lut_bit;
        end
    end

    // Registered or direct result
    assign tile_out_o = cfg.reg_en ? out_q : lut_bit;
    assign tile_oe_o  = cfg.oe;

endmodule

/* pad_input_mux.sv */
// Tile input source mux
`timescale 1ns/100ps
`include "fpga_consts.svh"

module pad_input_mux
    import pad_pkg::*;
    import fabric_pkg::*;
(
    input  logic [`MPRJ_IO_PADS-1:0]        io_in_i,
    input  logic [`FAB_LA_BITS-1:0]         la_data_in_i,
    input  logic [`FAB_LA_BITS-1:0]         la_oen_i,
    output tile_in_t [`FAB_N_TILES-1:0]     tile_in_o
);

    localparam int IN_BITS = `FAB_N_TILES * `FAB_LUT_K;

    pad_mode_e              mode;
    logic [`FAB_LA_BITS-1:0] la_masked;
    logic [IN_BITS-1:0]     gpio_bits;
    logic [IN_BITS-1:0]     la_bits;
    logic [IN_BITS-1:0]     src_bits;

    // Mode comes straight from its pad
    assign mode = pad_mode_e'(io_in_i[`PAD_MODE_PIN]);

    // Lines not enabled by the host read as 0
    assign la_masked = la_data_in_i & la_oen_i;

    // Pads 1 to 24 or analyzer lines 0 to 23
    assign gpio_bits = io_in_i[`PAD_IN_HI:`PAD_IN_LO];
    assign la_bits   = la_masked[IN_BITS-1:0];

    assign src_bits = (mode == PAD_MODE_LA) ? la_bits : gpio_bits;

    // Tile k gets bits 3k to 3k+2, lowest bit is LUT index bit 0
    assign tile_in_o = src_bits;

endmodule

/* pad_output_router.sv */
// Tile output router
`timescale 1ns/100ps
`include "fpga_consts.svh"

module pad_output_router (
    input  logic [`FAB_N_TILES-1:0]  tile_out_i,
    input  logic [`FAB_N_TILES-1:0]  tile_oe_i,
    input  logic                     busy_i,
    input  logic                     ccff_tail_i,
    input  logic [`FAB_LA_BITS-1:0]  la_oen_i,
    output logic [`MPRJ_IO_PADS-1:0] io_out_o,
    output logic [`MPRJ_IO_PADS-1:0] io_oeb_o,
    output logic [`FAB_LA_BITS-1:0]  la_data_out_o
);

    always_comb begin
        // Default every pad to input, every analyzer line low
        io_out_o      = '0;
        io_oeb_o      = '1;
        la_data_out_o = '0;

        for (int k = 0; k < `FAB_N_TILES; k++) begin
            // Output pads 25 to 32
            io_out_o[`PAD_OUT_LO + k] = tile_out_i[k];
            // oeb is active low, held off while the chain is loading
            io_oeb_o[`PAD_OUT_LO + k] = busy_i | ~tile_oe_i[k];

            // Analyzer lines 24 to 31, only where the host is not driving
            la_data_out_o[`LA_OUT_LO + k] = tile_out_i[k] & ~la_oen_i[`LA_OUT_LO + k];
        end

        // Chain tail is always observable
        io_out_o[`PAD_CCFF_TAIL] = ccff_tail_i;
        io_oeb_o[`PAD_CCFF_TAIL] = 1'b0;
    end

endmodule

/* fpga_fabric_top.sv */
// Fabric top level
`timescale 1ns/100ps
`include "fpga_consts.svh"

module fpga_fabric_top
    import fabric_pkg::*;
(
    input  logic                      wb_clk_i,
    input  logic                      reset_i,

    // Wishbone slave
    input  logic                      wbs_cyc_i,
    input  logic                      wbs_stb_i,
    input  logic                      wbs_we_i,
    input  logic [3:0]                wbs_sel_i,
    input  logic [31:0]               wbs_adr_i,
    input  logic [`FAB_WORD_BITS-1:0] wbs_dat_i,
    output logic                      wbs_ack_o,
    output logic [`FAB_WORD_BITS-1:0] wbs_dat_o,

    // Pads and analyzer lines
    input  logic [`MPRJ_IO_PADS-1:0]  io_in_i,
    input  logic [`FAB_LA_BITS-1:0]   la_data_in_i,
    input  logic [`FAB_LA_BITS-1:0]   la_oen_i,
    output logic [`MPRJ_IO_PADS-1:0]  io_out_o,
    output logic [`MPRJ_IO_PADS-1:0]  io_oeb_o,
    output logic [`FAB_LA_BITS-1:0]   la_data_out_o
);

    logic                        cfg_shift;
    logic                        busy;
    // chain[k+1] feeds tile k, chain[N] is the loader bit, chain[0] the tail
    logic [`FAB_N_TILES:0]       chain;
    tile_in_t [`FAB_N_TILES-1:0] tile_in;
    logic [`FAB_N_TILES-1:0]     tile_out;
    logic [`FAB_N_TILES-1:0]     tile_oe;

    config_loader u_loader (
        .wb_clk_i    (wb_clk_i),
        .reset_i     (reset_i),
        .wbs_cyc_i   (wbs_cyc_i),
        .wbs_stb_i   (wbs_stb_i),
        .wbs_we_i    (wbs_we_i),
        .wbs_sel_i   (wbs_sel_i),
        .wbs_adr_i   (wbs_adr_i),
        .wbs_dat_i   (wbs_dat_i),
        .wbs_ack_o   (wbs_ack_o),
        .wbs_dat_o   (wbs_dat_o),
        .cfg_shift_o (cfg_shift),
        .cfg_bit_o   (chain[`FAB_N_TILES]),
        .busy_o      (busy)
    );

    pad_input_mux u_in_mux (
        .io_in_i      (io_in_i),
        .la_data_in_i (la_data_in_i),
        .la_oen_i     (la_oen_i),
        .tile_in_o    (tile_in)
    );

    // Tile 7 is the chain head, tile 0 the tail
    for (genvar k = 0; k < `FAB_N_TILES; k++) begin : g_tile
        logic_tile u_tile (
            .wb_clk_i    (wb_clk_i),
            .reset_i     (reset_i),
            .cfg_shift_i (cfg_shift),
            .ccff_head_i (chain[k+1]),
            .tile_in_i   (tile_in[k]),
            .ccff_tail_o (chain[k]),
            .tile_out_o  (tile_out[k]),
            .tile_oe_o   (tile_oe[k])
        );
    end

    pad_output_router u_out_router (
        .tile_out_i    (tile_out),
        .tile_oe_i     (tile_oe),
        .busy_i        (busy),
        .ccff_tail_i   (chain[0]),
        .la_oen_i      (la_oen_i),
        .io_out_o      (io_out_o),
        .io_oeb_o      (io_oeb_o),
        .la_data_out_o (la_data_out_o)
    );

endmodule

/* tb_fpga_fabric.sv */
// Fabric random testbench
`timescale 1ns/100ps
`include "fpga_consts.svh"

module tb_fpga_fabric
    import fabric_pkg::*;
    import pad_pkg::*;
();

    localparam int ACK_TIMEOUT  = 64;
    localparam int IDLE_TIMEOUT = 40;
    localparam int N_STEPS      = 24;

    logic                      clk;
    logic                      reset;
    logic                      wbs_cyc;
    logic                      wbs_stb;
    logic                      wbs_we;
    logic [3:0]                wbs_sel;
    logic [31:0]               wbs_adr;
    logic [`FAB_WORD_BITS-1:0] wbs_dat_w;
    logic                      wbs_ack;
    logic [`FAB_WORD_BITS-1:0] wbs_dat_r;
    logic [`MPRJ_IO_PADS-1:0]  io_in;
    logic [`FAB_LA_BITS-1:0]   la_data_in;
    logic [`FAB_LA_BITS-1:0]   la_oen;
    logic [`MPRJ_IO_PADS-1:0]  io_out;
    logic [`MPRJ_IO_PADS-1:0]  io_oeb;
    logic [`FAB_LA_BITS-1:0]   la_data_out;

    // Chain image with tile 7 cfg bit 9 in bit 79 and tile 0 cfg bit 0 in bit 0
    logic [`FAB_CHAIN_BITS-1:0]         chain_m;
    // Tile inputs present at the last rising edge
    logic [`FAB_N_TILES*`FAB_LUT_K-1:0] prev_in;
    logic [`FAB_CHAIN_BITS-1:0]         img;
    logic [31:0]                        stat;
    logic [31:0]                        word_a;
    logic [31:0]                        word_b;
    int                                 cycles;

    fpga_fabric_top u_dut (
        .wb_clk_i      (clk),
        .reset_i       (reset),
        .wbs_cyc_i     (wbs_cyc),
        .wbs_stb_i     (wbs_stb),
        .wbs_we_i      (wbs_we),
        .wbs_sel_i     (wbs_sel),
        .wbs_adr_i     (wbs_adr),
        .wbs_dat_i     (wbs_dat_w),
        .wbs_ack_o     (wbs_ack),
        .wbs_dat_o     (wbs_dat_r),
        .io_in_i       (io_in),
        .la_data_in_i  (la_data_in),
        .la_oen_i      (la_oen),
        .io_out_o      (io_out),
        .io_oeb_o      (io_oeb),
        .la_data_out_o (la_data_out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_equal(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display(">>> FAIL");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out while waiting for %s", what);
        $display(">>> FAIL");
        $fatal(1, "Run stopped by timeout");
    endtask

    // Model of one word entering the chain LSB first at the tile 7 end
    task automatic model_shift_word(input logic [31:0] word);
        for (int i = 0; i < `FAB_WORD_BITS; i++) begin
            chain_m = {word[i], chain_m[`FAB_CHAIN_BITS-1:1]};
        end
    endtask

    function automatic tile_cfg_t cfg_of_tile(input logic [`FAB_CHAIN_BITS-1:0] image,
                                              input int k);
        return tile_cfg_t'(image[`FAB_CFG_BITS*k +: `FAB_CFG_BITS]);
    endfunction

    // Tile input bits as the mode pad selects them
    function automatic logic [23:0] tile_inputs(input logic [37:0] io_val,
                                                input logic [31:0] la_val,
                                                input logic [31:0] oen_val);
        logic [31:0] masked;
        masked = la_val & oen_val;
        if (io_val[`PAD_MODE_PIN]) begin
            return masked[23:0];
        end else begin
            return io_val[`PAD_IN_HI:`PAD_IN_LO];
        end
    endfunction

    // Random pads 1 to 24 with the mode pad set
    function automatic logic [37:0] rand_pads(input pad_mode_e mode);
        logic [37:0] v;
        v = '0;
        v[`PAD_IN_HI:`PAD_IN_LO] = 24'($urandom);
        v[`PAD_MODE_PIN] = mode;
        return v;
    endfunction

    // Random LUTs with oe set and reg_en taken from the mask
    function automatic logic [`FAB_CHAIN_BITS-1:0] make_image(input logic [7:0] reg_mask);
        logic [`FAB_CHAIN_BITS-1:0] image;
        tile_cfg_t cfg;
        for (int k = 0; k < `FAB_N_TILES; k++) begin
            cfg.oe     = 1'b1;
            cfg.reg_en = reg_mask[k];
            cfg.lut    = 8'($urandom);
            image[`FAB_CFG_BITS*k +: `FAB_CFG_BITS] = cfg;
        end
        return image;
    endfunction

    // Called on a falling edge
    task automatic start_cycle(input logic we, input logic [7:0] addr, input logic [31:0] data);
        wbs_cyc   = 1'b1;
        wbs_stb   = 1'b1;
        wbs_we    = we;
        wbs_sel   = 4'hF;
        wbs_adr   = {24'h0, addr};
        wbs_dat_w = data;
    endtask

    // Counts falling edges until ack and checks that output pads stay off while busy
    task automatic wait_ack(input int busy_cycles, output int count);
        logic seen;
        seen  = 1'b0;
        count = 0;
        while (!seen) begin
            @(negedge clk);
            count++;
            if (wbs_ack) begin
                seen = 1'b1;
            end else if (count >= ACK_TIMEOUT) begin
                report_timeout("the Wishbone ack");
            end else if (count <= busy_cycles) begin
                check_equal("io_oeb output pads while busy",
                            64'(io_oeb[`PAD_OUT_HI:`PAD_OUT_LO]), 64'(8'hFF));
            end
        end
        wbs_cyc = 1'b0;
        wbs_stb = 1'b0;
        wbs_we  = 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        int count;
        @(negedge clk);
        start_cycle(1'b1, addr, data);
        wait_ack(0, count);
        if (addr == `CFG_DATA_ADDR) begin
            model_shift_word(data);
        end
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
        int count;
        @(negedge clk);
        start_cycle(1'b0, addr, 32'h0);
        wait_ack(0, count);
        check_equal("read ack cycles", 64'(count), 64'(1));
        data = wbs_dat_r;
    endtask

    task automatic wait_idle();
        logic [31:0] status;
        int polls;
        polls  = 0;
        status = 32'h1;
        while (status[0]) begin
            read_reg(`CFG_STAT_ADDR, status);
            polls++;
            if (status[0] && polls >= IDLE_TIMEOUT) begin
                report_timeout("the loader to go idle");
            end
        end
    endtask

    // Three words whose first 16 stream bits fall off the tail
    task automatic load_image(input logic [`FAB_CHAIN_BITS-1:0] image);
        logic [3*`FAB_WORD_BITS-1:0] stream;
        stream = {image, 16'($urandom)};
        for (int j = 0; j < 3; j++) begin
            write_reg(`CFG_DATA_ADDR, stream[`FAB_WORD_BITS*j +: `FAB_WORD_BITS]);
        end
        wait_idle();
    endtask

    // Drive one input set and compare every pad and analyzer line with the model
    task automatic step_and_check(input logic [37:0] io_val, input logic [31:0] la_val,
                                  input logic [31:0] oen_val);
        logic [23:0] cur_in;
        logic [7:0]  exp_out;
        logic [7:0]  exp_oeb;
        logic [31:0] exp_la;
        tile_cfg_t   cfg;
        @(negedge clk);
        io_in      = io_val;
        la_data_in = la_val;
        la_oen     = oen_val;
        cur_in = tile_inputs(io_val, la_val, oen_val);
        exp_la = '0;
        for (int k = 0; k < `FAB_N_TILES; k++) begin
            cfg = cfg_of_tile(chain_m, k);
            // Registered tiles show the inputs of the last rising edge
            exp_out[k] = cfg.reg_en ? cfg.lut[prev_in[`FAB_LUT_K*k +: `FAB_LUT_K]]
                                    : cfg.lut[cur_in[`FAB_LUT_K*k +: `FAB_LUT_K]];
            exp_oeb[k] = ~cfg.oe;
            exp_la[`LA_OUT_LO + k] = exp_out[k] & ~oen_val[`LA_OUT_LO + k];
        end
        #5;
        check_equal("io_out output pads", 64'(io_out[`PAD_OUT_HI:`PAD_OUT_LO]), 64'(exp_out));
        check_equal("io_oeb output pads", 64'(io_oeb[`PAD_OUT_HI:`PAD_OUT_LO]), 64'(exp_oeb));
        check_equal("la_data_out", 64'(la_data_out), 64'(exp_la));
        check_equal("io_out chain tail", 64'(io_out[`PAD_CCFF_TAIL]), 64'(chain_m[0]));
        check_equal("io_oeb chain tail", 64'(io_oeb[`PAD_CCFF_TAIL]), 64'(0));
        check_equal("io_oeb input pads", 64'(io_oeb[24:0]), 64'({25{1'b1}}));
        check_equal("io_out input pads", 64'(io_out[24:0]), 64'(0));
        // Pads between the output group and the chain tail stay inputs
        check_equal("io_oeb spare pads",
                    64'(io_oeb[`PAD_CCFF_TAIL-1:`PAD_OUT_HI+1]), 64'(4'hF));
        check_equal("io_out spare pads",
                    64'(io_out[`PAD_CCFF_TAIL-1:`PAD_OUT_HI+1]), 64'(0));
        prev_in = cur_in;
    endtask

    initial begin
        void'($urandom(49295));
        reset      = 1'b1;
        wbs_cyc    = 1'b0;
        wbs_stb    = 1'b0;
        wbs_we     = 1'b0;
        wbs_sel    = 4'h0;
        wbs_adr    = '0;
        wbs_dat_w  = '0;
        io_in      = '0;
        la_data_in = '0;
        la_oen     = '0;
        chain_m    = '0;
        prev_in    = '0;
        repeat (4) @(negedge clk);
        reset = 1'b0;

        // After reset everything is off and idle
        @(negedge clk);
        check_equal("io_oeb after reset", 64'(io_oeb), 64'({1'b0, {37{1'b1}}}));
        check_equal("wbs_ack_o after reset", 64'(wbs_ack), 64'(0));
        read_reg(`CFG_STAT_ADDR, stat);
        check_equal("status after reset", 64'(stat), 64'(0));

        // Combinational LUTs on GPIO inputs
        img = make_image(8'h00);
        load_image(img);
        repeat (N_STEPS) step_and_check(rand_pads(PAD_MODE_GPIO), 32'h0, 32'h0);

        // Output register on random tiles
        img = make_image(8'($urandom));
        load_image(img);
        repeat (N_STEPS) step_and_check(rand_pads(PAD_MODE_GPIO), 32'h0, 32'h0);

        // Analyzer lines as the input source
        repeat (N_STEPS) step_and_check(rand_pads(PAD_MODE_LA), $urandom, $urandom);

        // Second write stalls for the whole first word and then acks
        word_a = $urandom;
        word_b = $urandom;
        write_reg(`CFG_DATA_ADDR, word_a);
        start_cycle(1'b1, `CFG_DATA_ADDR, word_b);
        wait_ack(31, cycles);
        check_equal("second write ack cycle", 64'(cycles), 64'(33));
        model_shift_word(word_b);
        write_reg(`CFG_DATA_ADDR, $urandom);
        read_reg(`CFG_STAT_ADDR, stat);
        check_equal("status while busy", 64'(stat), 64'(1));
        // Only the status register reads back busy
        read_reg(`CFG_DATA_ADDR, stat);
        check_equal("data register read", 64'(stat), 64'(0));
        wait_idle();
        // 96 shifts in all
        check_equal("chain tail pad", 64'(io_out[`PAD_CCFF_TAIL]), 64'(chain_m[0]));
        repeat (N_STEPS) step_and_check(rand_pads(PAD_MODE_GPIO), 32'h0, 32'h0);

        $display(">>> PASS");
        $finish;
    end

endmodule

/* fpga_fabric.f */
+incdir+.
fabric_pkg.sv
pad_pkg.sv
config_loader.sv
logic_tile.sv
pad_input_mux.sv
pad_output_router.sv
fpga_fabric_top.sv
tb_fpga_fabric.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the fabric testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timescale 1ns/100ps -f fpga_fabric.f --top-module tb_fpga_fabric
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/Vtb_fpga_fabric > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qxF '>>> PASS' "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi
